// File: bench/tb_fp_exec_cluster.sv
// ------------------------------------------------
// Testbench for the FP execution cluster
// Directed and random ops against a reference model
// ------------------------------------------------
`include "fpq_defs.svh"

module tb_fp_exec_cluster;

    localparam int QUEUE_DEPTH     = 8;
    localparam int SEED            = 32'h60e1f55d;
    localparam int N_INSTR         = 228;                 // All phases together
    localparam int WATCHDOG_CYCLES = N_INSTR * 70 + 200;

    typedef logic [`FPQ_DATA_W-1:0] data_t;
    typedef struct packed {
        logic [4:0]            rd;
        data_t                 data;
        logic [`FPQ_FLAG_W-1:0] flags;
    } entry_t;

    logic clk_i, rstn_i, flush_i, valid_i, wb_ready_i, full_o, wb_valid_o;
    fpq_pkg::fp_op_e   op_i;
    logic [4:0]        rd_i, wb_rd_o;
    data_t             src1_i, src2_i, wb_data_o;
    fpq_pkg::status_t  wb_fflags_o;

    int      seed = SEED;
    int      ready_seed = ~SEED;                       // Own stream for wb_ready_i
    int      ready_mode;                               // 0 high, 1 random, 2 low
    entry_t  exp_q[$];                                 // Expected write-backs, in order
    entry_t  exp_head, e;
    int      exp_count, cvt_left, accepted, retired, dropped, val_errs, other_errs;
    string   test_name;

    fp_exec_cluster #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (
        .clk_i(clk_i), .rstn_i(rstn_i), .flush_i(flush_i), .valid_i(valid_i),
        .op_i(op_i), .rd_i(rd_i), .src1_i(src1_i), .src2_i(src2_i),
        .wb_ready_i(wb_ready_i), .full_o(full_o), .wb_valid_o(wb_valid_o),
        .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .wb_fflags_o(wb_fflags_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic is_cvt(input fpq_pkg::fp_op_e op);
        return op == fpq_pkg::FCVT_D_L || op == fpq_pkg::FCVT_D_LU;
    endfunction

    function automatic logic is_nan(input data_t x);
        return x[62:52] == 11'h7ff && x[51:0] != 0;
    endfunction

    // Integer magnitude seen by the converter
    function automatic data_t magnitude(input fpq_pkg::fp_op_e op, input data_t a);
        return (op == fpq_pkg::FCVT_D_L && a[63]) ? ~a + 64'd1 : a;
    endfunction

    function automatic int cvt_latency(input fpq_pkg::fp_op_e op, input data_t a);
        data_t m;
        int    lz;
        m  = magnitude(op, a);
        lz = 0;
        if (m == 0)
            return 2;                                  // Zero goes straight to pack
        while (!m[63 - lz])
            lz++;
        return 2 + lz;
    endfunction

    // Expected result from the op rules, rd filled in later
    function automatic entry_t ref_result(input fpq_pkg::fp_op_e op, input data_t a, b);
        entry_t r;
        data_t  m, norm;
        int     p;
        real    ra, rb;
        logic   want_max;
        r = '0;
        want_max = (op == fpq_pkg::FMAX);
        case (op)
            fpq_pkg::FSGNJ:  r.data = {b[63], a[62:0]};
            fpq_pkg::FSGNJN: r.data = {!b[63], a[62:0]};
            fpq_pkg::FSGNJX: r.data = {a[63] ^ b[63], a[62:0]};
            fpq_pkg::FMIN, fpq_pkg::FMAX: begin
                ra = $bitstoreal(a);
                rb = $bitstoreal(b);
                if (is_nan(a) && is_nan(b))
                    r.data = fpq_pkg::CANONICAL_NAN;
                else if (is_nan(a))
                    r.data = b;
                else if (is_nan(b))
                    r.data = a;
                else if (ra == rb)
                    r.data = (a[63] != want_max) ? a : b;   // -0 below +0
                else
                    r.data = ((ra < rb) != want_max) ? a : b;
                r.flags[4] = (is_nan(a) && !a[51]) || (is_nan(b) && !b[51]);  // Signaling
            end
            default: begin
                m = magnitude(op, a);
                if (m != 0) begin
                    p = 63;
                    while (!m[p])
                        p--;
                    norm     = m << (63 - p);
                    r.data   = {op == fpq_pkg::FCVT_D_L && a[63], 11'(1023 + p), norm[62:11]};
                    r.flags[0] = |norm[10:0];           // Truncated bits
                end
            end
        endcase
        return r;
    endfunction

    function automatic data_t special(input int i);
        case (i)
            0: return 64'h0000_0000_0000_0000;  // +0
            1: return 64'h8000_0000_0000_0000;  // -0
            2: return 64'h7FF0_0000_0000_0000;  // +inf
            3: return 64'hFFF0_0000_0000_0000;  // -inf
            4: return 64'h7FF8_0000_0000_0000;  // Quiet NaN
            5: return 64'h7FF0_0000_0000_0001;  // Signaling NaN
            6: return 64'h3FF0_0000_0000_0000;  // 1.0
            default: return 64'hC004_0000_0000_0000;  // -2.5
        endcase
    endfunction

    // Present one op on the falling edge, hold it until accepted
    task automatic send(input fpq_pkg::fp_op_e op, input data_t a, input data_t b);
        @(negedge clk_i);
        valid_i = 1'b1;
        op_i    = op;
        rd_i    = $random(seed);
        src1_i  = a;
        src2_i  = b;
        @(posedge clk_i);
        while (full_o)
            @(posedge clk_i);
    endtask

    task automatic idle(input int n);
        @(negedge clk_i);
        valid_i = 1'b0;
        repeat (n) @(posedge clk_i);
    endtask

    function automatic data_t rand_data();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic fpq_pkg::fp_op_e rand_op(input int n);
        return fpq_pkg::fp_op_e'(3'($unsigned($random(seed)) % n));
    endfunction

    always @(negedge clk_i)
        wb_ready_i = (ready_mode == 0) || (ready_mode == 1 && ($random(ready_seed) & 3) != 0);

    // Reference model, tracks acceptance and retirement
    always @(posedge clk_i) begin
        if (!rstn_i || flush_i) begin
            dropped += exp_q.size();
            exp_q.delete();
            cvt_left = 0;
        end else begin
            if (cvt_left != 0)
                cvt_left--;
            if (wb_valid_o && wb_ready_i && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                retired++;
            end
            if (valid_i && !full_o) begin
                e    = ref_result(op_i, src1_i, src2_i);
                e.rd = rd_i;
                exp_q.push_back(e);
                accepted++;
                if (is_cvt(op_i))
                    cvt_left = cvt_latency(op_i, src1_i);  // Busy window
            end
        end
        exp_count = exp_q.size();
        exp_head  = (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i) wb_valid_o |-> exp_count != 0)
        else begin
            other_errs++;
            $display("%s: write-back seen with no instruction pending", test_name);
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_valid_o && exp_count != 0 |-> {wb_rd_o, wb_data_o, wb_fflags_o} == exp_head)
        else begin
            val_errs++;
            $display("** Error %s: expected rd %0d data %h flags %b, actual rd %0d data %h flags %b",
                     test_name, $sampled(exp_head.rd), $sampled(exp_head.data),
                     $sampled(exp_head.flags), $sampled(wb_rd_o), $sampled(wb_data_o),
                     $sampled(wb_fflags_o));
        end

    // Stalled write-back holds still
    assert property (@(posedge clk_i) disable iff (!rstn_i || flush_i)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable({wb_rd_o, wb_data_o, wb_fflags_o}))
        else begin
            other_errs++;
            $display("%s: write-back outputs changed while wb_ready_i was low", test_name);
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i) exp_count >= QUEUE_DEPTH |-> full_o)
        else begin
            other_errs++;
            $display("%s: full_o low with the queue full", test_name);
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_i && is_cvt(op_i) && cvt_left != 0 |-> full_o)
        else begin
            other_errs++;
            $display("%s: conversion accepted while the converter was busy", test_name);
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i) flush_i |=> !wb_valid_o)
        else begin
            other_errs++;
            $display("%s: write-back right after a flush", test_name);
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        data_t v;
        clk_i   = 1'b0;
        rstn_i  = 1'b0;
        flush_i = 1'b0;
        valid_i = 1'b0;
        op_i    = fpq_pkg::FSGNJ;
        rd_i    = '0;
        src1_i  = '0;
        src2_i  = '0;
        wb_ready_i = 1'b0;
        ready_mode = 0;
        test_name  = "reset";
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        test_name = "in_order";                        // Slow convert, fast ops behind
        send(fpq_pkg::FCVT_D_LU, 64'd1, '0);
        for (int k = 0; k < 6; k++)
            send(fpq_pkg::fp_op_e'(k % 5), rand_data(), rand_data());

        test_name = "sign_inject";
        for (int k = 0; k < 12; k++)
            send(fpq_pkg::fp_op_e'(k % 3), rand_data(), rand_data());

        test_name = "min_max";
        for (int i = 0; i < 8; i++)
            for (int j = 0; j < 8; j++) begin
                send(fpq_pkg::FMIN, special(i), special(j));
                send(fpq_pkg::FMAX, special(i), special(j));
            end

        test_name = "convert";
        send(fpq_pkg::FCVT_D_L, 64'd0, '0);
        send(fpq_pkg::FCVT_D_L, 64'd1, '0);
        send(fpq_pkg::FCVT_D_L, '1, '0);
        send(fpq_pkg::FCVT_D_L, 64'h8000_0000_0000_0000, '0);
        send(fpq_pkg::FCVT_D_LU, '1, '0);
        for (int k = 0; k < 16; k++) begin
            v = rand_data() >> ($unsigned($random(seed)) % 64);  // Spread of latencies
            send(($random(seed) & 1) ? fpq_pkg::FCVT_D_L : fpq_pkg::FCVT_D_LU, v, '0);
        end

        test_name = "back_pressure";
        idle(2);
        wait (exp_count == 0);
        ready_mode = 2;
        fork
            for (int k = 0; k < QUEUE_DEPTH + 1; k++)
                send(rand_op(5), rand_data(), rand_data());
            begin
                wait (exp_count == QUEUE_DEPTH);
                repeat (3) @(posedge clk_i);           // Hold full for a few cycles
                ready_mode = 0;
            end
        join

        test_name = "flush";
        idle(1);
        wait (exp_count == 0);
        ready_mode = 2;                                // Finished ops wait at the head
        for (int k = 0; k < 4; k++)
            send(rand_op(5), rand_data(), rand_data());
        send(fpq_pkg::FCVT_D_LU, 64'd3, '0);           // Still normalizing at the flush
        @(negedge clk_i);
        valid_i = 1'b0;
        flush_i = 1'b1;
        @(posedge clk_i);
        ready_mode = 0;
        @(negedge clk_i);
        flush_i = 1'b0;
        for (int k = 0; k < 6; k++)
            send(rand_op(7), rand_data(), rand_data());

        test_name  = "random";
        ready_mode = 1;
        for (int k = 0; k < 40; k++) begin
            send(rand_op(7), rand_data(), rand_data());
            if ($random(seed) & 1)
                idle(1 + ($unsigned($random(seed)) % 3));
        end

        test_name = "drain";
        idle(2);
        ready_mode = 0;
        wait (exp_count == 0);
        repeat (4) @(posedge clk_i);
        if (accepted != retired + dropped) begin
            other_errs++;
            $display("Instructions lost or duplicated: accepted %0d, retired %0d, flushed %0d",
                     accepted, retired, dropped);
        end
        $display("Accepted %0d, retired %0d, flushed %0d, value errors %0d, other errors %0d",
                 accepted, retired, dropped, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
src/fpq_pkg.sv
src/fp_result_if.sv
src/fp_sgnj_minmax_unit.sv
src/fp_int_to_double_unit.sv
src/pending_fp_ops_queue.sv
src/fp_exec_cluster.sv
bench/tb_fp_exec_cluster.sv

// File: include/fpq_defs.svh
// ------------------------------------------------
// FP execution cluster sizes
// Shared by the package and the testbench
// ------------------------------------------------
`ifndef FPQ_DEFS_SVH
`define FPQ_DEFS_SVH

`define FPQ_DATA_W 64 // Operand and result width
`define FPQ_TAG_W  5  // Queue tag width, wraps mod 32
`define FPQ_FLAG_W 5  // Accrued flag bits

`endif

// File: src/fp_exec_cluster.sv
// ------------------------------------------------
// FP execution cluster top level
// Queue plus sgnj/minmax and int-to-double units
// ------------------------------------------------
module fp_exec_cluster #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              flush_i,
    input  logic              valid_i,
    input  fpq_pkg::fp_op_e   op_i,
    input  logic [4:0]        rd_i,
    input  fpq_pkg::data_t    src1_i,
    input  fpq_pkg::data_t    src2_i,
    input  logic              wb_ready_i,
    output logic              full_o,
    output logic              wb_valid_o,
    output logic [4:0]        wb_rd_o,
    output fpq_pkg::data_t    wb_data_o,
    output fpq_pkg::status_t  wb_fflags_o
);

    fpq_pkg::fp_instr_t  instr;        // Dispatch ports packed
    fpq_pkg::fp_instr_t  issue_instr;
    fpq_pkg::tag_t       issue_tag;
    logic                issue_misc;
    logic                issue_cvt;
    logic                cvt_busy;

    fp_result_if misc_res_if ();       // sgnj/minmax to queue
    fp_result_if cvt_res_if ();        // Conversion to queue

    assign instr = '{op: op_i, rd: rd_i, src1: src1_i, src2: src2_i};

    pending_fp_ops_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .valid_i       (valid_i),
        .instr_i       (instr),
        .cvt_busy_i    (cvt_busy),
        .wb_ready_i    (wb_ready_i),
        .full_o        (full_o),
        .issue_misc_o  (issue_misc),
        .issue_cvt_o   (issue_cvt),
        .issue_instr_o (issue_instr),
        .issue_tag_o   (issue_tag),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_fflags_o   (wb_fflags_o),
        .misc_res      (misc_res_if.queue),
        .cvt_res       (cvt_res_if.queue)
    );

    fp_sgnj_minmax_unit misc0 (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_i),
        .issue_i (issue_misc),
        .instr_i (issue_instr),
        .tag_i   (issue_tag),
        .res     (misc_res_if.unit)
    );

    fp_int_to_double_unit cvt0 (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_i),
        .issue_i (issue_cvt),
        .instr_i (issue_instr),
        .tag_i   (issue_tag),
        .busy_o  (cvt_busy),
        .res     (cvt_res_if.unit)
    );

endmodule

// File: src/fp_int_to_double_unit.sv
// ------------------------------------------------
// Integer to double conversion unit
// One-bit-per-cycle normalize, truncating pack
// ------------------------------------------------
module fp_int_to_double_unit (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                flush_i,
    input  logic                issue_i,  // Issue strobe from the queue
    input  fpq_pkg::fp_instr_t  instr_i,
    input  fpq_pkg::tag_t       tag_i,
    output logic                busy_o,   // Issue edge up to the result pulse
    fp_result_if.unit           res
);

    typedef enum logic [1:0] {
        IDLE,
        NORMALIZE,
        PACK
    } cvt_state_e;

    cvt_state_e        state_q;
    fpq_pkg::data_t    mag_q;    // Magnitude, shifted toward bit 63
    logic              sign_q;
    logic [5:0]        cnt_q;    // Shift count = leading zeros
    fpq_pkg::tag_t     tag_q;
    logic              neg_in;   // Signed op with a negative source
    logic [10:0]       exp_w;

    assign neg_in = (instr_i.op == fpq_pkg::FCVT_D_L) && instr_i.src1[63];
    assign exp_w  = 11'd1086 - {5'd0, cnt_q}; // Bias 1023 plus 63
    assign busy_o = (state_q != IDLE);

    // Control FSM
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else if (flush_i) begin
            state_q <= IDLE;                          // Cancel the conversion
        end else begin
            case (state_q)
                IDLE: begin
                    if (issue_i)
                        state_q <= NORMALIZE;
                end
                NORMALIZE: begin
                    if (mag_q[63] || mag_q == '0)
                        state_q <= PACK;              // Leading one found, or zero
                end
                PACK:    state_q <= IDLE;             // Result pulse this cycle
                default: state_q <= IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && issue_i) begin
            sign_q <= neg_in;
            mag_q  <= neg_in ? -instr_i.src1 : instr_i.src1; // Min signed stays 2^63
            cnt_q  <= '0;
            tag_q  <= tag_i;
        end else if (state_q == NORMALIZE && !mag_q[63] && mag_q != '0) begin
            mag_q <= mag_q << 1;
            cnt_q <= cnt_q + 6'd1;
        end
    end

    // Pack, round toward zero
    always_comb begin
        res.valid = (state_q == PACK);
        res.tag   = tag_q;
        res.flags = '0;
        if (mag_q == '0) begin
            res.data = '0;                            // +0, no flags
        end else begin
            res.data     = {sign_q, exp_w, mag_q[62:11]};
            res.flags.nx = |mag_q[10:0];              // Dropped bits
        end
    end

    // Queue must hold conversions back while busy
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_i |-> !busy_o)
        else $error("conversion issued while unit busy");

endmodule

// File: src/fp_result_if.sv
// ------------------------------------------------
// Result path from one execution unit
// Tagged result and flags back to the queue
// ------------------------------------------------
interface fp_result_if;

    logic              valid; // One-cycle completion pulse
    fpq_pkg::tag_t     tag;   // Tag of the finished op
    fpq_pkg::data_t    data;
    fpq_pkg::status_t  flags;

    // Execution unit side
    modport unit (
        output valid, tag, data, flags
    );

    // Queue side, CAM lookup by tag
    modport queue (
        input valid, tag, data, flags
    );

endinterface

// File: src/fp_sgnj_minmax_unit.sv
// ------------------------------------------------
// Sign injection and min/max unit
// Two-stage pipeline, result 2 cycles after issue
// ------------------------------------------------
module fp_sgnj_minmax_unit (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                flush_i,
    input  logic                issue_i,  // Issue strobe from the queue
    input  fpq_pkg::fp_instr_t  instr_i,
    input  fpq_pkg::tag_t       tag_i,
    fp_result_if.unit           res
);

    // Stage 1 registers
    logic              s1_valid_q;
    fpq_pkg::fp_op_e   s1_op_q;
    fpq_pkg::tag_t     s1_tag_q;
    fpq_pkg::data_t    s1_a_q;
    fpq_pkg::data_t    s1_b_q;

    // Stage 2 result, before its register
    fpq_pkg::data_t    s2_data;
    fpq_pkg::status_t  s2_flags;
    logic              a_nan, b_nan;
    logic              a_lt_b;   // IEEE order, -0 below +0

    // Exponent all ones, mantissa nonzero
    function automatic logic is_nan(input fpq_pkg::data_t x);
        return (&x[62:52]) && (|x[51:0]);
    endfunction

    // Quiet bit clear
    function automatic logic is_snan(input fpq_pkg::data_t x);
        return is_nan(x) && !x[51];
    endfunction

    always_comb begin
        a_nan = is_nan(s1_a_q);
        b_nan = is_nan(s1_b_q);
        if (s1_a_q[63] != s1_b_q[63])
            a_lt_b = s1_a_q[63];                       // Negative one is smaller
        else if (s1_a_q[63])
            a_lt_b = s1_a_q[62:0] > s1_b_q[62:0];      // Both negative
        else
            a_lt_b = s1_a_q[62:0] < s1_b_q[62:0];

        s2_data  = s1_a_q;
        s2_flags = '0;
        case (s1_op_q)
            fpq_pkg::FSGNJ:  s2_data = {s1_b_q[63], s1_a_q[62:0]};
            fpq_pkg::FSGNJN: s2_data = {~s1_b_q[63], s1_a_q[62:0]};
            fpq_pkg::FSGNJX: s2_data = {s1_a_q[63] ^ s1_b_q[63], s1_a_q[62:0]};
            fpq_pkg::FMIN, fpq_pkg::FMAX: begin
                if (a_nan && b_nan)
                    s2_data = fpq_pkg::CANONICAL_NAN;
                else if (a_nan)
                    s2_data = s1_b_q;                  // The other operand wins
                else if (b_nan)
                    s2_data = s1_a_q;
                else if ((s1_op_q == fpq_pkg::FMIN) == a_lt_b)
                    s2_data = s1_a_q;
                else
                    s2_data = s1_b_q;
                s2_flags.nv = is_snan(s1_a_q) || is_snan(s1_b_q);
            end
            default: s2_data = s1_a_q;                 // Conversions never land here
        endcase
    end

    // Pipeline valids
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
            res.valid  <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;                        // Drop both ops in flight
            res.valid  <= 1'b0;
        end else begin
            s1_valid_q <= issue_i;
            res.valid  <= s1_valid_q;
        end
    end

    // Operands and result
    always_ff @(posedge clk_i) begin
        s1_op_q   <= instr_i.op;
        s1_tag_q  <= tag_i;
        s1_a_q    <= instr_i.src1;
        s1_b_q    <= instr_i.src2;
        res.tag   <= s1_tag_q;
        res.data  <= s2_data;
        res.flags <= s2_flags;
    end

    // Nothing enters the pipeline alongside a flush
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |-> !issue_i)
        else $error("sgnj/minmax op issued during a flush");

endmodule

// File: src/fpq_pkg.sv
// ------------------------------------------------
// FP execution cluster types
// Opcodes, accrued flags, tags and instructions
// ------------------------------------------------
`include "fpq_defs.svh"

package fpq_pkg;

    typedef logic [`FPQ_DATA_W-1:0] data_t; // One double or one 64-bit integer
    typedef logic [`FPQ_TAG_W-1:0]  tag_t;  // Queue entry tag

    // Opcodes handled by the cluster
    typedef enum logic [2:0] {
        FSGNJ,
        FSGNJN,
        FSGNJX,
        FMIN,
        FMAX,
        FCVT_D_L,  // Signed long to double
        FCVT_D_LU  // Unsigned long to double
    } fp_op_e;

    // Accrued flags, RISC-V fflags order (nv is bit 4)
    typedef struct packed {
        logic nv; // Invalid operation
        logic dz; // Divide by zero
        logic of; // Overflow
        logic uf; // Underflow
        logic nx; // Inexact
    } status_t;

    // Instruction after register read
    typedef struct packed {
        fp_op_e     op;
        logic [4:0] rd;   // Destination register
        data_t      src1;
        data_t      src2;
    } fp_instr_t;

    // Default quiet NaN
    localparam data_t CANONICAL_NAN = 64'h7FF8_0000_0000_0000;

endpackage

// File: src/pending_fp_ops_queue.sv
// ------------------------------------------------
// Pending FP operation queue
// Tags and issues ops, collects results by tag,
// writes back in program order
// ------------------------------------------------
module pending_fp_ops_queue #(
    parameter int QUEUE_DEPTH = 8   // 2 to 16, keeps live tags unique
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                flush_i,
    input  logic                valid_i,
    input  fpq_pkg::fp_instr_t  instr_i,
    input  logic                cvt_busy_i,
    input  logic                wb_ready_i,
    output logic                full_o,
    output logic                issue_misc_o,   // To sgnj/minmax unit
    output logic                issue_cvt_o,    // To conversion unit
    output fpq_pkg::fp_instr_t  issue_instr_o,
    output fpq_pkg::tag_t       issue_tag_o,
    output logic                wb_valid_o,
    output logic [4:0]          wb_rd_o,
    output fpq_pkg::data_t      wb_data_o,
    output fpq_pkg::status_t    wb_fflags_o,
    fp_result_if.queue          misc_res,
    fp_result_if.queue          cvt_res
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [PTR_W-1:0]  head_q, tail_q;
    logic [PTR_W:0]    count_q;       // One bit wider than the pointers
    fpq_pkg::tag_t     tag_cnt_q;     // Next tag to hand out

    // Entry table
    logic [QUEUE_DEPTH-1:0]  valid_q;
    logic [QUEUE_DEPTH-1:0]  done_q;
    logic [4:0]              rd_q    [QUEUE_DEPTH];
    fpq_pkg::tag_t           tag_q   [QUEUE_DEPTH];
    fpq_pkg::data_t          data_q  [QUEUE_DEPTH];
    fpq_pkg::status_t        flags_q [QUEUE_DEPTH];

    logic                    is_cvt;
    logic                    write_en;
    logic                    retire_en;
    logic [QUEUE_DEPTH-1:0]  misc_hit, cvt_hit;   // CAM match vectors

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign is_cvt = (instr_i.op == fpq_pkg::FCVT_D_L) || (instr_i.op == fpq_pkg::FCVT_D_LU);

    // Stall on full queue, busy converter, flush or reset
    assign full_o = (count_q == QUEUE_DEPTH) || (is_cvt && cvt_busy_i) || flush_i || !rstn_i;

    assign write_en      = valid_i && !full_o;
    assign issue_misc_o  = write_en && !is_cvt;
    assign issue_cvt_o   = write_en && is_cvt;
    assign issue_instr_o = instr_i;
    assign issue_tag_o   = tag_cnt_q;

    // Head writes back once its result is in
    assign wb_valid_o  = valid_q[head_q] && done_q[head_q];
    assign wb_rd_o     = rd_q[head_q];
    assign wb_data_o   = data_q[head_q];
    assign wb_fflags_o = flags_q[head_q];
    assign retire_en   = wb_valid_o && wb_ready_i;

    // Tag match against every live entry
    always_comb begin
        for (int j = 0; j < QUEUE_DEPTH; j++) begin
            misc_hit[j] = misc_res.valid && valid_q[j] && !done_q[j]
                          && (tag_q[j] == misc_res.tag);
            cvt_hit[j]  = cvt_res.valid && valid_q[j] && !done_q[j]
                          && (tag_q[j] == cvt_res.tag);
        end
    end

    // Pointers, count and tag counter
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
            tag_cnt_q <= '0;
        end else if (flush_i) begin
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
            tag_cnt_q <= '0;                            // Tags restart at 0
        end else begin
            if (write_en) begin
                tail_q    <= next_ptr(tail_q);
                tag_cnt_q <= tag_cnt_q + 1'b1;          // Wraps mod 32
            end
            if (retire_en)
                head_q <= next_ptr(head_q);
            count_q <= count_q + {{PTR_W{1'b0}}, write_en} - {{PTR_W{1'b0}}, retire_en};
        end
    end

    // Entry valid and done bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
            done_q  <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            done_q <= done_q | misc_hit | cvt_hit;      // Both units may finish together
            if (write_en) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
            end
            if (retire_en) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            rd_q[tail_q]  <= instr_i.rd;
            tag_q[tail_q] <= tag_cnt_q;
        end
        for (int j = 0; j < QUEUE_DEPTH; j++) begin
            if (misc_hit[j]) begin
                data_q[j]  <= misc_res.data;
                flags_q[j] <= misc_res.flags;
            end else if (cvt_hit[j]) begin
                data_q[j]  <= cvt_res.data;
                flags_q[j] <= cvt_res.flags;
            end
        end
    end

    // Never accept into a full table
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (issue_misc_o || issue_cvt_o) |-> !valid_q[tail_q] && count_q < QUEUE_DEPTH)
        else $error("queue written while full");

    // Units only report live, unfinished tags
    assert property (@(posedge clk_i) disable iff (!rstn_i || flush_i)
        misc_res.valid |-> $onehot(misc_hit))
        else $error("misc result tag matches no single pending entry");

    assert property (@(posedge clk_i) disable iff (!rstn_i || flush_i)
        cvt_res.valid |-> $onehot(cvt_hit))
        else $error("cvt result tag matches no single pending entry");

endmodule
